//--- flist.f
rtl/capture_pkg.sv
rtl/capture_regs.sv
rtl/clock_monitor.sv
rtl/trigger_ctrl.sv
rtl/sample_buffer.sv
rtl/adc_capture_top.sv
tests/tb_adc_capture.sv

//--- rtl/adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top import capture_pkg::*; (
	input  wire                   slowclock,
	input  wire                   freq_measure,
	input  wire [ADC_BITS-1:0]    adc_data_i,
	input  wire                   adc_or_i,
	input  wire                   trigger_i,
	input  wire                   ext_clk_i,
	input  wire [REG_AW-1:0]      reg_addr_i,
	input  wire                   reg_wr_i,
	input  wire [REG_DW-1:0]      reg_wdata_i,
	input  wire                   reg_rd_i,
	input  wire                   rd_credit_i,
	output logic [REG_DW-1:0]     reg_rdata_o,
	output logic                  sample_valid_o,
	output logic [SAMPLE_BITS-1:0] sample_data_o,
	output logic                  amp_gain_o,
	output logic                  amp_hilo_o,
	output logic                  heartbeat_led_o,
	output logic                  armed_led_o,
	output logic                  capture_led_o
);

	logic                    arm_req, trig_mode, trig_wait, trig_now;
	logic                    armed, capture_go, trig_sync;
	logic                    capture_done, buf_empty;
	logic [FIFO_AW:0]        max_samples;
	logic [FREQ_GATE_BITS:0] freq_count;

	assign armed_led_o   = armed;
	assign capture_led_o = capture_go;   // Lit for the whole capture run

	capture_regs u_regs (
		.slowclock     (slowclock),
		.freq_measure  (freq_measure),
		.reg_addr_i    (reg_addr_i),
		.reg_wr_i      (reg_wr_i),
		.reg_wdata_i   (reg_wdata_i),
		.reg_rd_i      (reg_rd_i),
		.armed_i       (armed),
		.capture_go_i  (capture_go),
		.trig_sync_i   (trig_sync),
		.buf_empty_i   (buf_empty),
		.freq_count_i  (freq_count),
		.reg_rdata_o   (reg_rdata_o),
		.arm_req_o     (arm_req),
		.trig_mode_o   (trig_mode),
		.trig_wait_o   (trig_wait),
		.trig_now_o    (trig_now),
		.max_samples_o (max_samples),
		.amp_gain_o    (amp_gain_o),
		.amp_hilo_o    (amp_hilo_o)
	);

	clock_monitor u_clkmon (
		.slowclock       (slowclock),
		.freq_measure    (freq_measure),
		.ext_clk_i       (ext_clk_i),
		.heartbeat_led_o (heartbeat_led_o),
		.freq_count_o    (freq_count)
	);

	trigger_ctrl u_trig (
		.slowclock      (slowclock),
		.freq_measure   (freq_measure),
		.trigger_i      (trigger_i),
		.arm_req_i      (arm_req),
		.trig_mode_i    (trig_mode),
		.trig_wait_i    (trig_wait),
		.trig_now_i     (trig_now),
		.capture_done_i (capture_done),
		.armed_o        (armed),
		.capture_go_o   (capture_go),
		.trig_sync_o    (trig_sync)
	);

	sample_buffer u_buf (
		.slowclock      (slowclock),
		.freq_measure   (freq_measure),
		.adc_data_i     (adc_data_i),
		.adc_or_i       (adc_or_i),
		.capture_go_i   (capture_go),
		.max_samples_i  (max_samples),
		.rd_credit_i    (rd_credit_i),
		.capture_done_o (capture_done),
		.buf_empty_o    (buf_empty),
		.sample_valid_o (sample_valid_o),
		.sample_data_o  (sample_data_o)
	);

endmodule

`default_nettype wire

//--- rtl/capture_pkg.sv
`default_nettype none

package capture_pkg;

	// Sample path
	localparam int ADC_BITS    = 10;
	localparam int SAMPLE_BITS = ADC_BITS + 1;      // Overrange bit on top
	localparam int FIFO_DEPTH  = 64;
	localparam int FIFO_AW     = $clog2(FIFO_DEPTH);

	// Host register port
	localparam int REG_AW = 3;
	localparam int REG_DW = 32;

	localparam int GAIN_BITS      = 8;
	localparam int FREQ_GATE_BITS = 10;             // 1024 cycle gate window
	localparam int HEARTBEAT_BIT  = 8;
	localparam int CREDIT_BITS    = 4;

	localparam logic [REG_AW-1:0] ADDR_CTRL    = REG_AW'(0);
	localparam logic [REG_AW-1:0] ADDR_GAIN    = REG_AW'(1);
	localparam logic [REG_AW-1:0] ADDR_MAXSAMP = REG_AW'(2);
	localparam logic [REG_AW-1:0] ADDR_STATUS  = REG_AW'(3);
	localparam logic [REG_AW-1:0] ADDR_FREQ    = REG_AW'(4);

	// CTRL bits, write-only
	localparam int CTRL_ARM  = 0;
	localparam int CTRL_MODE = 1;
	localparam int CTRL_WAIT = 2;
	localparam int CTRL_NOW  = 3;
	localparam int CTRL_HILO = 4;

	// STATUS bits
	localparam int ST_ARMED = 0;
	localparam int ST_IDLE  = 1;
	localparam int ST_TRIG  = 2;
	localparam int ST_EMPTY = 3;

endpackage

`default_nettype wire

//--- rtl/capture_regs.sv
`timescale 1ns/1ps
`default_nettype none

module capture_regs import capture_pkg::*; (
	input  wire                    slowclock,
	input  wire                    freq_measure,
	input  wire [REG_AW-1:0]       reg_addr_i,
	input  wire                    reg_wr_i,
	input  wire [REG_DW-1:0]       reg_wdata_i,
	input  wire                    reg_rd_i,
	input  wire                    armed_i,
	input  wire                    capture_go_i,
	input  wire                    trig_sync_i,
	input  wire                    buf_empty_i,
	input  wire [FREQ_GATE_BITS:0] freq_count_i,
	output logic [REG_DW-1:0]      reg_rdata_o,
	output logic                   arm_req_o,
	output logic                   trig_mode_o,
	output logic                   trig_wait_o,
	output logic                   trig_now_o,
	output logic [FIFO_AW:0]       max_samples_o,
	output logic                   amp_gain_o,
	output logic                   amp_hilo_o
);

	logic [GAIN_BITS-1:0] gain_q;
	logic [GAIN_BITS:0]   pwm_acc;   // Top bit is the carry out
	logic [REG_DW-1:0]    status_word;
	logic                 ctrl_wr;

	assign ctrl_wr = reg_wr_i && (reg_addr_i == ADDR_CTRL);

	always_comb begin
		status_word = '0;
		status_word[ST_ARMED] = armed_i;
		status_word[ST_IDLE]  = ~capture_go_i;
		status_word[ST_TRIG]  = trig_sync_i;
		status_word[ST_EMPTY] = buf_empty_i;
	end

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			trig_mode_o   <= 1'b0;
			trig_wait_o   <= 1'b0;
			amp_hilo_o    <= 1'b0;
			arm_req_o     <= 1'b0;
			trig_now_o    <= 1'b0;
			gain_q        <= '0;
			max_samples_o <= (FIFO_AW+1)'(FIFO_DEPTH);
		end else begin
			// One pulse per CTRL write cycle
			arm_req_o  <= ctrl_wr && reg_wdata_i[CTRL_ARM];
			trig_now_o <= ctrl_wr && reg_wdata_i[CTRL_NOW];
			if (ctrl_wr) begin
				trig_mode_o <= reg_wdata_i[CTRL_MODE];
				trig_wait_o <= reg_wdata_i[CTRL_WAIT];
				amp_hilo_o  <= reg_wdata_i[CTRL_HILO];
			end
			if (reg_wr_i && reg_addr_i == ADDR_GAIN)
				gain_q <= reg_wdata_i[GAIN_BITS-1:0];
			if (reg_wr_i && reg_addr_i == ADDR_MAXSAMP) begin
				if (reg_wdata_i == '0)
					max_samples_o <= (FIFO_AW+1)'(1);
				else if (reg_wdata_i > REG_DW'(FIFO_DEPTH))
					max_samples_o <= (FIFO_AW+1)'(FIFO_DEPTH);
				else
					max_samples_o <= reg_wdata_i[FIFO_AW:0];
			end
		end
	end

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			reg_rdata_o <= '0;
		end else if (reg_rd_i) begin
			case (reg_addr_i)
				ADDR_GAIN:    reg_rdata_o <= REG_DW'(gain_q);
				ADDR_MAXSAMP: reg_rdata_o <= REG_DW'(max_samples_o);
				ADDR_STATUS:  reg_rdata_o <= status_word;
				ADDR_FREQ:    reg_rdata_o <= REG_DW'(freq_count_i);
				default:      reg_rdata_o <= '0;   // CTRL reads as zero
			endcase
		end
	end

	// Gain PWM, carry rate is gain/256
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure)
			pwm_acc <= '0;
		else
			pwm_acc <= {1'b0, pwm_acc[GAIN_BITS-1:0]} + {1'b0, gain_q};
	end

	assign amp_gain_o = pwm_acc[GAIN_BITS];

	a_single_pulse: assert property (@(posedge slowclock) disable iff (!freq_measure)
		(arm_req_o |=> !arm_req_o) and (trig_now_o |=> !trig_now_o));

endmodule

`default_nettype wire

//--- rtl/clock_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module clock_monitor import capture_pkg::*; (
	input  wire                     slowclock,
	input  wire                     freq_measure,
	input  wire                     ext_clk_i,
	output logic                    heartbeat_led_o,
	output logic [FREQ_GATE_BITS:0] freq_count_o
);

	logic [FREQ_GATE_BITS-1:0] timer_q;
	logic [FREQ_GATE_BITS:0]   edge_cnt;
	logic                      ext_meta, ext_sync, ext_prev;
	logic                      ext_rise;
	logic                      gate_end;

	// Free-running timer, also the gate window
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure)
			timer_q <= '0;
		else
			timer_q <= timer_q + 1'b1;
	end

	assign heartbeat_led_o = timer_q[HEARTBEAT_BIT];
	assign gate_end        = &timer_q;   // Last cycle of the window

	// External clock is asynchronous to slowclock
	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			ext_meta <= 1'b0;
			ext_sync <= 1'b0;
			ext_prev <= 1'b0;
		end else begin
			ext_meta <= ext_clk_i;
			ext_sync <= ext_meta;
			ext_prev <= ext_sync;
		end
	end

	assign ext_rise = ext_sync & ~ext_prev;

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			edge_cnt     <= '0;
			freq_count_o <= '0;
		end else if (gate_end) begin
			// Include an edge seen on the closing cycle
			freq_count_o <= edge_cnt + {{FREQ_GATE_BITS{1'b0}}, ext_rise};
			edge_cnt     <= '0;
		end else begin
			edge_cnt <= edge_cnt + {{FREQ_GATE_BITS{1'b0}}, ext_rise};
		end
	end

endmodule

`default_nettype wire

//--- rtl/sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_buffer import capture_pkg::*; (
	input  wire                     slowclock,
	input  wire                     freq_measure,
	input  wire  [ADC_BITS-1:0]     adc_data_i,
	input  wire                     adc_or_i,
	input  wire                     capture_go_i,
	input  wire  [FIFO_AW:0]        max_samples_i,
	input  wire                     rd_credit_i,
	output logic                    capture_done_o,
	output logic                    buf_empty_o,
	output logic                    sample_valid_o,
	output logic [SAMPLE_BITS-1:0]  sample_data_o
);

	logic [SAMPLE_BITS-1:0] adc_q;                 // {overrange, data}
	logic [SAMPLE_BITS-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW:0]       wr_ptr, rd_ptr, remain;
	logic [CREDIT_BITS-1:0] credit_cnt;
	logic                   go_d, running, go_start;
	logic                   wr_en, rd_en, buf_full, credit_add;

	assign go_start    = capture_go_i & ~go_d;
	assign wr_en       = running;
	assign buf_empty_o = (wr_ptr == rd_ptr);
	assign buf_full    = (wr_ptr == {~rd_ptr[FIFO_AW], rd_ptr[FIFO_AW-1:0]});
	assign credit_add  = rd_credit_i && !(&credit_cnt);   // Saturate at 15
	assign rd_en       = (credit_cnt != '0) && !buf_empty_o && !go_start;

	always_ff @(posedge slowclock) begin
		adc_q <= {adc_or_i, adc_data_i};
		if (wr_en)
			mem[wr_ptr[FIFO_AW-1:0]] <= adc_q;
		if (rd_en)
			sample_data_o <= mem[rd_ptr[FIFO_AW-1:0]];
	end

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			go_d <= 1'b0; running <= 1'b0; capture_done_o <= 1'b0;
			wr_ptr <= '0; rd_ptr <= '0; remain <= '0;
			credit_cnt <= '0; sample_valid_o <= 1'b0;
		end else begin
			go_d           <= capture_go_i;
			capture_done_o <= 1'b0;
			sample_valid_o <= rd_en;
			credit_cnt     <= credit_cnt + CREDIT_BITS'(credit_add) - CREDIT_BITS'(rd_en);
			if (go_start) begin
				// Flush whatever the last run left behind
				wr_ptr  <= '0;
				rd_ptr  <= '0;
				remain  <= max_samples_i;
				running <= 1'b1;
			end else begin
				if (rd_en)
					rd_ptr <= rd_ptr + 1'b1;
				if (wr_en) begin
					wr_ptr <= wr_ptr + 1'b1;
					remain <= remain - 1'b1;
					if (remain == (FIFO_AW+1)'(1)) begin
						running        <= 1'b0;
						capture_done_o <= 1'b1;
					end
				end
			end
		end
	end

	a_no_wr_full: assert property (@(posedge slowclock) disable iff (!freq_measure)
		!(wr_en && buf_full));
	a_valid_credit: assert property (@(posedge slowclock) disable iff (!freq_measure)
		sample_valid_o |-> $past(credit_cnt) != '0);

endmodule

`default_nettype wire

//--- rtl/trigger_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_ctrl import capture_pkg::*; (
	input  wire  slowclock,
	input  wire  freq_measure,
	input  wire  trigger_i,
	input  wire  arm_req_i,
	input  wire  trig_mode_i,      // 1 fires on high level, 0 on low
	input  wire  trig_wait_i,
	input  wire  trig_now_i,
	input  wire  capture_done_i,
	output logic armed_o,
	output logic capture_go_o,
	output logic trig_sync_o
);

	logic trig_meta;
	logic trig_active;
	logic arm_pending;   // Waiting for the trigger to go inactive

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			trig_meta   <= 1'b0;
			trig_sync_o <= 1'b0;
		end else begin
			trig_meta   <= trigger_i;
			trig_sync_o <= trig_meta;
		end
	end

	assign trig_active = (trig_sync_o == trig_mode_i);

	always_ff @(posedge slowclock or negedge freq_measure) begin
		if (!freq_measure) begin
			arm_pending  <= 1'b0;
			armed_o      <= 1'b0;
			capture_go_o <= 1'b0;
		end else if (capture_go_o) begin
			if (capture_done_i)
				capture_go_o <= 1'b0;
		end else if (armed_o) begin
			// Level match or software trigger fires the capture
			if (trig_active || trig_now_i) begin
				armed_o      <= 1'b0;
				capture_go_o <= 1'b1;
			end
		end else if (arm_pending) begin
			if (!trig_active) begin
				arm_pending <= 1'b0;
				armed_o     <= 1'b1;
			end
		end else if (arm_req_i) begin
			if (trig_wait_i)
				arm_pending <= 1'b1;
			else
				armed_o <= 1'b1;
		end
	end

	a_arm_go_excl: assert property (@(posedge slowclock) disable iff (!freq_measure)
		!(armed_o && capture_go_o));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the capture front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f flist.f --top-module tb_adc_capture -o sim_adc_capture
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_adc_capture)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" <<< "$output"; then
	exit 0
fi
exit 1

//--- tests/tb_adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture import capture_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000;

	logic                   slowclock, freq_measure;
	logic [ADC_BITS-1:0]    adc_data_i;
	logic                   adc_or_i, trigger_i, ext_clk_i;
	logic [REG_AW-1:0]      reg_addr_i;
	logic                   reg_wr_i, reg_rd_i, rd_credit_i;
	logic [REG_DW-1:0]      reg_wdata_i, reg_rdata_o;
	logic                   sample_valid_o;
	logic [SAMPLE_BITS-1:0] sample_data_o;
	logic                   amp_gain_o, amp_hilo_o;
	logic                   heartbeat_led_o, armed_led_o, capture_led_o;

	int checks, errors, cycle_cnt;
	int granted, received, run_count, gap, ext_div;
	logic credit_on, first_sample;
	logic [ADC_BITS-1:0] prev_data;

	adc_capture_top dut0 (.*);

	initial begin
		slowclock = 1'b0;
		forever #50 slowclock = ~slowclock;
	end

	task automatic next_cycle();
		@(posedge slowclock);
		#5;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Fail %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic write_reg(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
		reg_addr_i  = addr;
		reg_wdata_i = data;
		reg_wr_i    = 1'b1;
		next_cycle();
		reg_wr_i    = 1'b0;
	endtask

	// Data is registered on the edge that samples reg_rd_i
	task automatic read_reg(input logic [REG_AW-1:0] addr, output logic [REG_DW-1:0] data);
		reg_addr_i = addr;
		reg_rd_i   = 1'b1;
		next_cycle();
		reg_rd_i   = 1'b0;
		data       = reg_rdata_o;
	endtask

	task automatic run_capture(input int n);
		logic [REG_DW-1:0] rd;
		logic [REG_DW-1:0] exp_st;
		run_count    = 0;
		first_sample = 1'b1;
		credit_on    = 1'b1;
		while (!capture_led_o) next_cycle();
		while (run_count < 5) next_cycle();
		credit_on = 1'b0;                     // Back-pressure with data held
		repeat (25) next_cycle();
		credit_on = 1'b1;
		while (capture_led_o) next_cycle();
		while (run_count < n) next_cycle();
		repeat (30) next_cycle();             // Extra credits must not fetch more
		check_value("sample count", 32'(n), 32'(run_count));
		credit_on = 1'b0;
		exp_st = '0;
		exp_st[ST_IDLE]  = 1'b1;
		exp_st[ST_EMPTY] = 1'b1;
		exp_st[ST_TRIG]  = trigger_i;
		read_reg(ADDR_STATUS, rd);
		check_value("status after capture", exp_st, rd);
	endtask

	// Ramp, external clock and credit grants
	always begin
		@(posedge slowclock);
		#5;
		adc_data_i = adc_data_i + 1'b1;
		adc_or_i   = &adc_data_i[3:0];
		ext_div    = ext_div + 1;
		if (ext_div == 8) begin
			ext_div   = 0;
			ext_clk_i = ~ext_clk_i;
		end
		if (credit_on && gap == 0 && (granted - received) < 15) begin
			rd_credit_i = 1'b1;
			gap = int'($urandom % 4);
		end else begin
			rd_credit_i = 1'b0;
			if (gap > 0) gap--;
		end
	end

	// Sample monitor, credits counted as the DUT sees them
	always begin
		@(posedge slowclock);
		#1;
		if (freq_measure) begin
			if (sample_valid_o) begin
				checks++;
				assert (granted > received) else begin
					errors++;
					$display("A sample came out with no credit outstanding");
				end
				check_value("sample_data_o overrange", 32'(&sample_data_o[3:0]),
					32'(sample_data_o[SAMPLE_BITS-1]));
				if (!first_sample)
					check_value("sample_data_o", 32'(prev_data + 1'b1),
						32'(sample_data_o[ADC_BITS-1:0]));
				first_sample = 1'b0;
				prev_data    = sample_data_o[ADC_BITS-1:0];
				received++;
				run_count++;
			end
			if (rd_credit_i) granted++;
		end
	end

	a_arm_go_excl: assert property (@(posedge slowclock) disable iff (!freq_measure)
		!(armed_led_o && capture_led_o)) else begin
		errors++;
		$display("Armed and capture LEDs were lit together");
	end

	a_arm_drop: assert property (@(posedge slowclock) disable iff (!freq_measure)
		$rose(capture_led_o) |-> $past(armed_led_o) && !armed_led_o) else begin
		errors++;
		$display("Capture started without the armed state dropping on the same edge");
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge slowclock);
			cycle_cnt++;
		end
		$display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("checks %0d errors %0d", checks, errors + 1);
		$display("tests failed");
		$finish;
	end

	initial begin
		logic [REG_DW-1:0] rd;
		logic [7:0] gain_val;
		logic hb_level;
		int cnt;
		freq_measure = 1'b0;
		adc_data_i   = '0;
		adc_or_i     = 1'b0;
		trigger_i    = 1'b0;
		ext_clk_i    = 1'b0;
		reg_addr_i   = '0;
		reg_wr_i     = 1'b0;
		reg_wdata_i  = '0;
		reg_rd_i     = 1'b0;
		rd_credit_i  = 1'b0;
		checks       = 0;
		errors       = 0;
		granted      = 0;
		received     = 0;
		run_count    = 0;
		gap          = 0;
		ext_div      = 0;
		credit_on    = 1'b0;
		first_sample = 1'b1;
		prev_data    = '0;
		void'($urandom(32'hfa15));
		repeat (16) @(posedge slowclock);
		#5 freq_measure = 1'b1;

		check_value("outputs after reset", 32'h0,
			32'({armed_led_o, capture_led_o, sample_valid_o, amp_gain_o, amp_hilo_o}));
		read_reg(ADDR_STATUS, rd);
		check_value("status after reset", 32'((1 << ST_IDLE) | (1 << ST_EMPTY)), rd);
		read_reg(ADDR_MAXSAMP, rd);
		check_value("maxsamp after reset", 32'(FIFO_DEPTH), rd);
		write_reg(ADDR_MAXSAMP, 32'd100);
		read_reg(ADDR_MAXSAMP, rd);
		check_value("maxsamp clamp high", 32'd64, rd);
		write_reg(ADDR_MAXSAMP, 32'd0);
		read_reg(ADDR_MAXSAMP, rd);
		check_value("maxsamp clamp low", 32'd1, rd);

		// PWM duty over one full accumulator period
		repeat (2) begin
			gain_val = 8'($urandom);
			write_reg(ADDR_GAIN, 32'(gain_val));
			read_reg(ADDR_GAIN, rd);
			check_value("gain readback", 32'(gain_val), rd);
			next_cycle();
			cnt = 0;
			repeat (256) begin
				if (amp_gain_o) cnt++;
				next_cycle();
			end
			check_value("amp_gain_o high cycles", 32'(gain_val), 32'(cnt));
		end
		write_reg(ADDR_CTRL, 32'(1 << CTRL_HILO));
		check_value("amp_hilo_o", 32'd1, 32'(amp_hilo_o));
		write_reg(ADDR_CTRL, 32'h0);
		check_value("amp_hilo_o", 32'd0, 32'(amp_hilo_o));

		// LED toggles every 256 cycles
		hb_level = heartbeat_led_o;
		while (heartbeat_led_o == hb_level) next_cycle();
		hb_level = heartbeat_led_o;
		cnt      = 0;
		while (heartbeat_led_o == hb_level) begin
			cnt++;
			next_cycle();
		end
		check_value("heartbeat_led_o half period", 32'd256, 32'(cnt));

		repeat (2100) next_cycle();           // Two full gate windows
		read_reg(ADDR_FREQ, rd);
		checks++;
		assert (rd >= 32'd63 && rd <= 32'd65) else begin
			errors++;
			$display("Fail freq_count expected %h got %h", 32'd64, rd);
		end

		// Level trigger capture
		write_reg(ADDR_MAXSAMP, 32'd20);
		write_reg(ADDR_CTRL, 32'((1 << CTRL_ARM) | (1 << CTRL_MODE)));
		while (!armed_led_o) next_cycle();
		trigger_i = 1'b1;
		run_capture(20);

		// Trigger already active, arming waits for it to go inactive
		write_reg(ADDR_CTRL, 32'((1 << CTRL_ARM) | (1 << CTRL_MODE) | (1 << CTRL_WAIT)));
		repeat (40) begin
			checks++;
			assert (!capture_led_o && !armed_led_o) else begin
				errors++;
				$display("Armed or captured while the trigger never went inactive");
			end
			next_cycle();
		end
		trigger_i = 1'b0;
		while (!armed_led_o) next_cycle();
		repeat (3) next_cycle();
		trigger_i = 1'b1;
		run_capture(20);

		// Software trigger with the trigger input inactive
		trigger_i = 1'b0;
		write_reg(ADDR_MAXSAMP, 32'd12);
		write_reg(ADDR_CTRL, 32'((1 << CTRL_ARM) | (1 << CTRL_MODE)));
		while (!armed_led_o) next_cycle();
		repeat (10) next_cycle();
		check_value("capture_led_o before software trigger", 32'd0, 32'(capture_led_o));
		write_reg(ADDR_CTRL, 32'((1 << CTRL_NOW) | (1 << CTRL_MODE)));
		run_capture(12);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
